// File: hw/rotatorCfgPkg.sv
`default_nettype none

package rotatorCfgPkg;

   // ------------------------------
   // Sample and angle formats
   // ------------------------------

   // Width of each I and Q value
   localparam int sampleBits = 8;

   // 5-bit angle gives 32 steps per turn
   localparam int angleBits = 5;

   // Coefficients are signed with 6 fraction bits, so 64 stands for 1.0
   localparam int coefBits = 8;
   localparam int coefFrac = 6;

   // Full precision of one sample times one coefficient
   localparam int prodBits = sampleBits + coefBits;

   // Symmetric clamp limits, the most negative code is never produced
   localparam int satMax = 127;
   localparam int satMin = -127;

   // ------------------------------
   // Unit phasor tables
   // ------------------------------

   // Entry k is round(64 * cos(2*pi*k/32))
   localparam logic signed [coefBits-1:0] cosTable [0:(1 << angleBits) - 1] = '{
       64,  63,  59,  53,  45,  36,  24,  12,
        0, -12, -24, -36, -45, -53, -59, -63,
      -64, -63, -59, -53, -45, -36, -24, -12,
        0,  12,  24,  36,  45,  53,  59,  63
   };

   // Entry k is round(64 * sin(2*pi*k/32))
   localparam logic signed [coefBits-1:0] sinTable [0:(1 << angleBits) - 1] = '{
        0,  12,  24,  36,  45,  53,  59,  63,
       64,  63,  59,  53,  45,  36,  24,  12,
        0, -12, -24, -36, -45, -53, -59, -63,
      -64, -63, -59, -53, -45, -36, -24, -12
   };

   // ------------------------------
   // Pipeline and queue sizing
   // ------------------------------

   // Cycles from rotator input valid to rotator output valid
   localparam int rotLatency = 3;

   // Output queue entries, a power of two so the pointers wrap by themselves
   localparam int queueDepth = 4;
   localparam int queueIdxBits = $clog2(queueDepth);

   // Credit and fill counters must hold 0 up to queueDepth
   localparam int creditBits = $clog2(queueDepth + 1);

endpackage

`default_nettype wire

// File: hw/sampleTypesPkg.sv
`default_nettype none

package sampleTypesPkg;

   // One signed I or Q value
   typedef logic signed [rotatorCfgPkg::sampleBits-1:0] iqValue_t;

   // Rotation angle, wraps modulo 32
   typedef logic [rotatorCfgPkg::angleBits-1:0] angle_t;

   // Signed phase increment carried with every sample
   typedef logic signed [rotatorCfgPkg::angleBits-1:0] phaseStep_t;

   // Word on the input handshake port
   typedef struct packed {
      iqValue_t   i;
      iqValue_t   q;
      phaseStep_t step;
      logic       resync;
   } inWord_t;

   typedef struct packed {
      iqValue_t i;
      iqValue_t q;
   } iqPair_t;

   // Tracker to rotator
   typedef struct packed {
      logic    valid;
      angle_t  angle;
      iqPair_t iq;
   } rotWord_t;

   // Rotator to output queue
   typedef struct packed {
      logic    valid;
      iqPair_t iq;
   } outWord_t;

endpackage

`default_nettype wire

// File: hw/sampleIn.sv
`timescale 1ns/1ps
`default_nettype none

module sampleIn (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic                    inReq,
   input  wire sampleTypesPkg::inWord_t inData,
   input  wire logic                    creditAvail,
   output logic                         inAck,
   output sampleTypesPkg::inWord_t      inSample,
   output logic                         accept
);

   typedef enum logic {
      idle,
      acked
   } rxState_t;

   rxState_t state;

   // ------------------------------
   // Four-phase receiver
   // ------------------------------

   // A word is only taken when the output queue has room reserved for it
   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= idle;
         accept <= 1'b0;
      end else begin
         accept <= 1'b0;
         case (state)
            idle: begin
               if (inReq && creditAvail) begin
                  accept <= 1'b1;
                  state  <= acked;
               end
            end
            acked: begin
               // Hold the acknowledge until the source drops its request
               if (!inReq)
                  state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

   // Capture register for the accepted word
   always_ff @(posedge clk) begin
      if (state == idle && inReq && creditAvail)
         inSample <= inData;
   end

   // Acknowledge is high for as long as the receiver sits in acked
   assign inAck = (state == acked);

endmodule

`default_nettype wire

// File: hw/phaseTracker.sv
`timescale 1ns/1ps
`default_nettype none

module phaseTracker (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire sampleTypesPkg::inWord_t inSample,
   input  wire logic                    accept,
   output sampleTypesPkg::rotWord_t     rotIn
);

   sampleTypesPkg::angle_t  angle;
   sampleTypesPkg::angle_t  nextAngle;
   sampleTypesPkg::iqPair_t iqReg;
   logic                    valid;

   // Resync loads the step as an absolute angle, otherwise the steps accumulate
   // and the 5-bit sum wraps modulo one turn
   assign nextAngle = inSample.resync ? sampleTypesPkg::angle_t'(inSample.step)
                                      : angle + sampleTypesPkg::angle_t'(inSample.step);

   always_ff @(posedge clk) begin
      if (reset) begin
         angle <= '0;
         valid <= 1'b0;
      end else begin
         valid <= accept;
         if (accept)
            angle <= nextAngle;
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         iqReg <= '{i: inSample.i, q: inSample.q};
   end

   assign rotIn = '{valid: valid, angle: angle, iq: iqReg};

endmodule

`default_nettype wire

// File: hw/phaseRotator.sv
`timescale 1ns/1ps
`default_nettype none

module phaseRotator (
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire sampleTypesPkg::rotWord_t rotIn,
   output sampleTypesPkg::outWord_t      rotOut
);

   typedef logic signed [rotatorCfgPkg::coefBits-1:0] coef_t;
   typedef logic signed [rotatorCfgPkg::prodBits-1:0] product_t;
   typedef logic signed [rotatorCfgPkg::prodBits:0]   sum_t;

   // Valid bit shifts alongside the three data stages
   logic [rotatorCfgPkg::rotLatency-1:0] validPipe;

   coef_t                    cosReg;
   coef_t                    sinReg;
   sampleTypesPkg::iqValue_t iReg;
   sampleTypesPkg::iqValue_t qReg;

   product_t ixCos;
   product_t qxSin;
   product_t ixSin;
   product_t qxCos;

   sum_t iSum;
   sum_t qSum;

   sampleTypesPkg::iqValue_t iOut;
   sampleTypesPkg::iqValue_t qOut;

   // Drop the coefficient fraction bits, then clamp to the symmetric range
   function automatic sampleTypesPkg::iqValue_t saturate(input sum_t value);
      sum_t scaled;
      scaled = value >>> rotatorCfgPkg::coefFrac;
      if (scaled > sum_t'(rotatorCfgPkg::satMax))
         return sampleTypesPkg::iqValue_t'(rotatorCfgPkg::satMax);
      else if (scaled < sum_t'(rotatorCfgPkg::satMin))
         return sampleTypesPkg::iqValue_t'(rotatorCfgPkg::satMin);
      else
         return sampleTypesPkg::iqValue_t'(scaled);
   endfunction

   always_ff @(posedge clk) begin
      if (reset)
         validPipe <= '0;
      else
         validPipe <= {validPipe[rotatorCfgPkg::rotLatency-2:0], rotIn.valid};
   end

   // ------------------------------
   // Stage 1, phasor lookup
   // ------------------------------

   always_ff @(posedge clk) begin
      cosReg <= rotatorCfgPkg::cosTable[rotIn.angle];
      sinReg <= rotatorCfgPkg::sinTable[rotIn.angle];
      iReg   <= rotIn.iq.i;
      qReg   <= rotIn.iq.q;
   end

   // ------------------------------
   // Stage 2, four products
   // ------------------------------

   always_ff @(posedge clk) begin
      ixCos <= product_t'(iReg) * product_t'(cosReg);
      qxSin <= product_t'(qReg) * product_t'(sinReg);
      ixSin <= product_t'(iReg) * product_t'(sinReg);
      qxCos <= product_t'(qReg) * product_t'(cosReg);
   end

   // ------------------------------
   // Stage 3, sums and rescale
   // ------------------------------

   // One guard bit keeps the sum of two full products exact
   assign iSum = sum_t'(ixCos) - sum_t'(qxSin);
   assign qSum = sum_t'(ixSin) + sum_t'(qxCos);

   always_ff @(posedge clk) begin
      iOut <= saturate(iSum);
      qOut <= saturate(qSum);
   end

   assign rotOut = '{
      valid: validPipe[rotatorCfgPkg::rotLatency-1],
      iq:    '{i: iOut, q: qOut}
   };

endmodule

`default_nettype wire

// File: hw/sampleOut.sv
`timescale 1ns/1ps
`default_nettype none

module sampleOut (
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire sampleTypesPkg::outWord_t rotOut,
   input  wire logic                     accept,
   input  wire logic                     outAck,
   output logic                          creditAvail,
   output logic                          outReq,
   output sampleTypesPkg::iqPair_t       outData
);

   typedef logic [rotatorCfgPkg::queueIdxBits-1:0] queueIdx_t;
   typedef logic [rotatorCfgPkg::creditBits-1:0]   count_t;

   typedef enum logic {
      idle,
      waitAckLow
   } txState_t;

   sampleTypesPkg::iqPair_t queue [rotatorCfgPkg::queueDepth];

   queueIdx_t wrPtr;
   queueIdx_t rdPtr;
   count_t    fill;
   count_t    credits;
   txState_t  state;
   logic      push;
   logic      pop;

   assign push = rotOut.valid;

   // The word leaves the queue when the sink acknowledges it
   assign pop = (state == idle) && outReq && outAck;

   // ------------------------------
   // Circular queue
   // ------------------------------

   always_ff @(posedge clk) begin
      if (push)
         queue[wrPtr] <= rotOut.iq;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         fill  <= '0;
      end else begin
         if (push)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // Head entry stays put until the pop, so the data is stable under outReq
   assign outData = queue[rdPtr];

   // ------------------------------
   // Credit counter
   // ------------------------------

   // A credit is spent when a word is accepted at the input, which reserves
   // its queue slot for the whole trip through the pipeline
   always_ff @(posedge clk) begin
      if (reset) begin
         credits <= count_t'(rotatorCfgPkg::queueDepth);
      end else begin
         case ({accept, pop})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   assign creditAvail = (credits != '0);

   // ------------------------------
   // Four-phase sender
   // ------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= idle;
         outReq <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (outReq && outAck) begin
                  outReq <= 1'b0;
                  state  <= waitAckLow;
               end else if (!outReq && (fill != '0 || push)) begin
                  // A word arriving at an empty queue is offered one cycle later
                  outReq <= 1'b1;
               end
            end
            waitAckLow: begin
               if (!outAck)
                  state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/derotator.sv
`timescale 1ns/1ps
`default_nettype none

module derotator (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic                    inReq,
   input  wire sampleTypesPkg::inWord_t inData,
   output logic                         inAck,
   output logic                         outReq,
   output sampleTypesPkg::iqPair_t      outData,
   input  wire logic                    outAck
);

   sampleTypesPkg::inWord_t  inSample;
   sampleTypesPkg::rotWord_t rotIn;
   sampleTypesPkg::outWord_t rotOut;
   logic                     accept;
   logic                     creditAvail;

   // Input side
   sampleIn inPort (
      .clk         (clk),
      .reset       (reset),
      .inReq       (inReq),
      .inData      (inData),
      .creditAvail (creditAvail),
      .inAck       (inAck),
      .inSample    (inSample),
      .accept      (accept)
   );

   // Processing part
   phaseTracker tracker (
      .clk      (clk),
      .reset    (reset),
      .inSample (inSample),
      .accept   (accept),
      .rotIn    (rotIn)
   );

   phaseRotator rotator (
      .clk    (clk),
      .reset  (reset),
      .rotIn  (rotIn),
      .rotOut (rotOut)
   );

   // Output side, which also returns the credits to the input side
   sampleOut outPort (
      .clk         (clk),
      .reset       (reset),
      .rotOut      (rotOut),
      .accept      (accept),
      .outAck      (outAck),
      .creditAvail (creditAvail),
      .outReq      (outReq),
      .outData     (outData)
   );

endmodule

`default_nettype wire

// File: testbench/derotator_assert.sv
`timescale 1ns/1ps
`default_nettype none

module derotatorAssert (
   input wire logic                    clk,
   input wire logic                    reset,
   input wire logic                    inReq,
   input wire sampleTypesPkg::inWord_t inData,
   input wire logic                    inAck,
   input wire logic                    outReq,
   input wire sampleTypesPkg::iqPair_t outData,
   input wire logic                    outAck,
   input wire logic                    accept
);

   int failCount = 0;

   // Words taken at the input that the sink has not yet acknowledged
   int inFlight;

   always @(posedge clk) begin
      if (reset)
         inFlight <= 0;
      else
         inFlight <= inFlight + int'(accept) - int'(outReq && outAck);
   end

   // The source holds its word for the whole request phase
   inDataStable: assert property (@(posedge clk) disable iff (reset)
      inReq && $past(inReq) |-> $stable(inData))
      else begin
         $error("Input word changed while inReq was high");
         failCount++;
      end

   // The head entry must not move while it is being offered
   outDataStable: assert property (@(posedge clk) disable iff (reset)
      outReq && $past(outReq) |-> $stable(outData))
      else begin
         $error("Output word changed while outReq was high");
         failCount++;
      end

   // The queue holds queueDepth words, so one more accept would overrun it
   acceptNeedsCredit: assert property (@(posedge clk) disable iff (reset)
      accept |-> inFlight < rotatorCfgPkg::queueDepth)
      else begin
         $error("A word was accepted while no credit was left");
         failCount++;
      end

   // ------------------------------
   // Reset state
   // ------------------------------

   handshakeLowInReset: assert property (@(posedge clk)
      reset |=> !inAck && !outReq)
      else begin
         $error("inAck or outReq was high during or right after reset");
         failCount++;
      end

endmodule

bind derotator derotatorAssert protocolChecks (
   .clk     (clk),
   .reset   (reset),
   .inReq   (inReq),
   .inData  (inData),
   .inAck   (inAck),
   .outReq  (outReq),
   .outData (outData),
   .outAck  (outAck),
   .accept  (accept)
);

`default_nettype wire

// File: testbench/derotatorTb.sv
`timescale 1ns/1ps
`default_nettype none

module derotatorTb;

   localparam int identityCount = 16;
   localparam int accumCount    = 200;
   localparam int satCount      = 8;
   localparam int pressureCount = 64;
   localparam int burstCount    = 12;
   localparam int restartCount  = 8;
   localparam int totalSamples  = identityCount + accumCount + satCount + pressureCount
                                  + burstCount + restartCount;
   localparam real pi = 3.14159265358979;

   logic                    clk = 1'b0;
   logic                    reset;
   logic                    inReq;
   sampleTypesPkg::inWord_t inData;
   logic                    inAck;
   logic                    outReq;
   sampleTypesPkg::iqPair_t outData;
   logic                    outAck = 1'b0;

   // Reference model, one expected pair per word handed to the DUT
   sampleTypesPkg::iqPair_t expected [$];
   sampleTypesPkg::iqPair_t expectedHead;
   logic                    expectPending;
   int                      modelAngle;
   string                   testName;
   int                      maxAckDelay;
   int                      ackDelay = 0;
   logic                    abortSend;

   always #2 clk = ~clk;

   derotator DUT (
      .clk     (clk),
      .reset   (reset),
      .inReq   (inReq),
      .inData  (inData),
      .inAck   (inAck),
      .outReq  (outReq),
      .outData (outData),
      .outAck  (outAck)
   );

   function automatic int roundCoef(input real x);
      return (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
   endfunction

   function automatic int scaleClamp(input int sum);
      int scaled;
      scaled = sum >>> rotatorCfgPkg::coefFrac;
      if (scaled > rotatorCfgPkg::satMax)
         return rotatorCfgPkg::satMax;
      if (scaled < rotatorCfgPkg::satMin)
         return rotatorCfgPkg::satMin;
      return scaled;
   endfunction

   // Multiply by the unit phasor 64 * exp(j * 2 * pi * angle / 32)
   function automatic sampleTypesPkg::iqPair_t rotateRef(input int i, input int q, input int angle);
      real                     theta;
      int                      c;
      int                      s;
      sampleTypesPkg::iqPair_t result;
      theta = 2.0 * pi * angle / 32.0;
      c = roundCoef(64.0 * $cos(theta));
      s = roundCoef(64.0 * $sin(theta));
      result.i = sampleTypesPkg::iqValue_t'(scaleClamp(i * c - q * s));
      result.q = sampleTypesPkg::iqValue_t'(scaleClamp(i * s + q * c));
      return result;
   endfunction

   function automatic sampleTypesPkg::inWord_t randomWord(input int step, input logic resync);
      sampleTypesPkg::inWord_t word;
      word.i      = sampleTypesPkg::iqValue_t'(int'($urandom_range(254, 0)) - 127);
      word.q      = sampleTypesPkg::iqValue_t'(int'($urandom_range(254, 0)) - 127);
      word.step   = sampleTypesPkg::phaseStep_t'(step);
      word.resync = resync;
      return word;
   endfunction

   task automatic refreshHead();
      expectPending = (expected.size() != 0);
      if (expectPending)
         expectedHead = expected[0];
   endtask

   task automatic addExpected(input sampleTypesPkg::inWord_t word);
      if (word.resync)
         modelAngle = int'(word.step) & 31;
      else
         modelAngle = (modelAngle + int'(word.step)) & 31;
      expected.push_back(rotateRef(int'(word.i), int'(word.q), modelAngle));
      refreshHead();
   endtask

   // One four-phase transfer, entered and left on a falling edge
   task automatic sendWord(input sampleTypesPkg::inWord_t word);
      inData = word;
      inReq  = 1'b1;
      addExpected(word);
      while (!inAck && !abortSend)
         @(negedge clk);
      inReq = 1'b0;
      while (inAck && !abortSend)
         @(negedge clk);
   endtask

   task automatic drainOutput();
      while (expected.size() != 0)
         @(negedge clk);
      repeat (8) @(negedge clk);
   endtask

   // ------------------------------
   // Sink with random acknowledge delay
   // ------------------------------

   always @(negedge clk) begin
      if (reset) begin
         outAck   = 1'b0;
         ackDelay = 0;
      end else if (outAck && !outReq) begin
         // Request has dropped, so the word is complete and leaves the model
         outAck = 1'b0;
         if (expected.size() != 0)
            void'(expected.pop_front());
         refreshHead();
      end else if (outReq && !outAck) begin
         if (ackDelay > 0) begin
            ackDelay--;
         end else begin
            outAck   = 1'b1;
            ackDelay = $urandom_range(maxAckDelay, 0);
         end
      end
   end

   outputMatch: assert property (@(posedge clk) disable iff (reset)
      $rose(outReq) && expectPending |-> outData == expectedHead)
      else begin
         $display("MISMATCH %s expected i=%0d q=%0d actual i=%0d q=%0d", testName,
                  expectedHead.i, expectedHead.q, $sampled(outData.i), $sampled(outData.q));
         $display("Regression failed");
         $fatal(1, "Output value check failed");
      end

   noExtraOutput: assert property (@(posedge clk) disable iff (reset)
      $rose(outReq) |-> expectPending)
      else begin
         $display("An output word arrived in %s while no sample was outstanding", testName);
         $display("Regression failed");
         $fatal(1, "Unexpected output word");
      end

   // The most negative code must never leave the rotator
   noMinCode: assert property (@(posedge clk) disable iff (reset)
      outReq |-> outData.i != 8'h80 && outData.q != 8'h80)
      else begin
         $display("Output in %s carried the code -128", testName);
         $display("Regression failed");
         $fatal(1, "Saturation check failed");
      end

   initial begin
      wait (DUT.protocolChecks.failCount != 0);
      $display("Regression failed");
      $fatal(1, "Protocol assertion failed");
   end

   initial begin
      repeat (totalSamples * 40 + 2000) @(posedge clk);
      $display("Watchdog expired before all samples came back");
      $display("Regression failed");
      $fatal(1, "Timeout");
   end

   initial begin
      sampleTypesPkg::inWord_t word;
      void'($urandom(32'h92d00d71));
      reset         = 1'b1;
      inReq         = 1'b0;
      inData        = '0;
      modelAngle    = 0;
      maxAckDelay   = 0;
      abortSend     = 1'b0;
      expectPending = 1'b0;
      expectedHead  = '0;
      testName      = "identity";
      repeat (10) @(negedge clk);
      reset = 1'b0;

      for (int n = 0; n < identityCount; n++)
         sendWord(randomWord(0, 1'b1));
      drainOutput();

      testName = "accumulate";
      for (int n = 0; n < accumCount; n++)
         sendWord(randomWord($urandom_range(31, 0), $urandom_range(9, 0) == 0));
      drainOutput();

      // Full scale inputs at 45 degrees overflow the rescaled sums
      testName = "saturation";
      for (int n = 0; n < satCount; n++) begin
         word.i      = n[0] ? -8'sd127 : 8'sd127;
         word.q      = n[1] ? -8'sd127 : 8'sd127;
         word.step   = 5'sd4;
         word.resync = 1'b1;
         sendWord(word);
      end
      drainOutput();

      testName    = "backPressure";
      maxAckDelay = 30;
      for (int n = 0; n < pressureCount; n++)
         sendWord(randomWord($urandom_range(31, 0), $urandom_range(9, 0) == 0));
      drainOutput();

      // Reset lands while the slow sink keeps words in flight
      testName = "midReset";
      fork
         begin
            for (int n = 0; n < burstCount; n++)
               if (!abortSend)
                  sendWord(randomWord($urandom_range(31, 0), 1'b0));
         end
      join_none
      repeat (60) @(negedge clk);
      abortSend = 1'b1;
      repeat (2) @(negedge clk);
      reset = 1'b1;
      inReq = 1'b0;
      expected.delete();
      refreshHead();
      modelAngle = 0;
      repeat (10) @(negedge clk);
      reset       = 1'b0;
      abortSend   = 1'b0;
      maxAckDelay = 0;

      // Zero steps without resync only give identity if the angle restarted at 0
      testName = "restart";
      for (int n = 0; n < restartCount; n++)
         sendWord(randomWord(0, 1'b0));
      drainOutput();

      if (DUT.protocolChecks.failCount != 0) begin
         $display("Regression failed");
         $fatal(1, "Protocol assertion failed");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: derotator.f
hw/rotatorCfgPkg.sv
hw/sampleTypesPkg.sv
hw/sampleIn.sv
hw/phaseTracker.sv
hw/phaseRotator.sv
hw/sampleOut.sv
hw/derotator.sv
testbench/derotator_assert.sv
testbench/derotatorTb.sv
